// ==== list.f ====
+incdir+include
design/heapApbPkg.sv
design/heapOpPkg.sv
design/heapCommandDecoder.sv
design/heapArrayBank.sv
design/heapResponseCollector.sv
design/heapTop.sv
testbench/heapTb_chk.sv
testbench/heapTb.sv

// ==== Bender.yml ====
package:
  name: heap_array

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/heapApbPkg.sv
      - design/heapOpPkg.sv
      - design/heapCommandDecoder.sv
      - design/heapArrayBank.sv
      - design/heapResponseCollector.sv
      - design/heapTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/heapTb_chk.sv
      - testbench/heapTb.sv

// ==== testbench/heapTb.sv ====
/*
  Testbench of the APB array heap. A reference model predicts every result.
  Elements that were never written are not read back, as the RAM has no reset.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapTb;
  import heapOpPkg::*;
  import heapApbPkg::*;

  localparam int plannedTransfers = 146;                 // Command, result and status read each
  localparam int cycleLimit       = plannedTransfers * 6 + 40;

  logic    clock;
  logic    reset;
  apbReqT  apbReq;
  apbRespT apbResp;

  // --------------------------------------------------------------------------
  // Reference model of the heap
  // --------------------------------------------------------------------------
  logic [`HEAP_ARRAYS-1:0] modelAlloc;                   // Allocation table
  int                      modelHigh;                    // Arrays ever handed out
  int                      freeList [$];                 // Back is newest freed
  int                      modelSize [`HEAP_ARRAYS];
  heapDataT                modelMem [`HEAP_ARRAYS][`HEAP_LENGTH];

  integer      seed       = 32'hb03b_af85;
  int          cycleCount = 0;
  int          checkCount = 0;
  int          errorCount = 0;
  int          testCount  = 0;
  int          errorsBefore;                             // Errors when a test started
  heapDataT    gotData;
  logic [31:0] gotStatus;
  heapDataT    pushed [`HEAP_LENGTH];
  int          probeIndex [4] = '{30, 20, 10, 15};
  int          probeCount [4] = '{35, 25, 15, 5};
  logic [31:0] rdata;
  logic        slverr;

  heapTop DUT (
    .clock   (clock),
    .reset   (reset),
    .apbReq  (apbReq),
    .apbResp (apbResp)
  );

  always #20 clock = ~clock;                             // 40 ns period

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: tests still running after %0d cycles", cycleCount);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Immediate check errors plus bound assertion failures
  function automatic int totalErrors();
    return errorCount + DUT.chk.failCount;
  endfunction

  // One APB transfer, setup then access until pready
  task automatic apbTransfer(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] data,
                             output logic err);
    @(posedge clock);
    apbReq.psel    <= 1'b1;
    apbReq.penable <= 1'b0;
    apbReq.pwrite  <= write;
    apbReq.paddr   <= addr;
    apbReq.pwdata  <= wdata;
    @(posedge clock);
    apbReq.penable <= 1'b1;
    do @(negedge clock); while (!apbResp.pready);        // Sample mid cycle
    data = apbResp.prdata;
    err  = apbResp.pslverr;
    @(posedge clock);
    apbReq.psel    <= 1'b0;
    apbReq.penable <= 1'b0;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Expected data and error of one command, and model update
  task automatic predict(input heapOpT op, input int arr, input int idx,
                         input heapDataT data, output heapDataT expData,
                         output heapErrorT expErr);
    int count;
    count   = 0;
    expData = '0;
    expErr  = errNone;
    if (op == opReset) begin
      modelAlloc = '0;
      modelHigh  = 0;
      freeList.delete();
    end else if (op == opAlloc) begin
      if (freeList.size() > 0 || modelHigh < `HEAP_ARRAYS) begin
        if (freeList.size() > 0) begin
          arr = freeList.pop_back();                     // Newest freed first
        end else begin
          arr = modelHigh;
          modelHigh++;
        end
        modelAlloc[arr] = 1'b1;
        modelSize[arr]  = 0;
        expData         = heapDataT'(arr);
      end else begin
        expErr = errNoFreeArray;
      end
    end else if (!modelAlloc[arr]) begin
      expErr = errNotAllocated;
    end else begin
      case (op)
        opFree: begin
          modelAlloc[arr] = 1'b0;
          freeList.push_back(arr);
        end
        opWrite: begin
          modelMem[arr][idx] = data;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1; // Grows the size
          expData = data;
        end
        opRead: begin
          if (idx < modelSize[arr]) expData = modelMem[arr][idx];
          else expErr = errOutOfBounds;
        end
        opSize: expData = heapDataT'(modelSize[arr]);
        opPush: begin
          if (modelSize[arr] < `HEAP_LENGTH) begin
            modelMem[arr][modelSize[arr]] = data;
            modelSize[arr]++;
            expData = data;
          end else begin
            expErr = errFull;
          end
        end
        opPop: begin
          if (modelSize[arr] > 0) begin
            modelSize[arr]--;
            expData = modelMem[arr][modelSize[arr]];
          end else begin
            expErr = errEmpty;
          end
        end
        default: begin                                   // Index, Less, Greater
          for (int i = 0; i < modelSize[arr]; i++) begin
            if (op == opIndex && modelMem[arr][i] == data) count = i + 1;
            if (op == opLess && modelMem[arr][i] < data) count++;
            if (op == opGreater && modelMem[arr][i] > data) count++;
          end
          expData = heapDataT'(count);
        end
      endcase
    end
  endtask

  // Command write, then result and status reads, all checked against the model
  task automatic runCommand(input heapOpT op, input int arr, input int idx,
                            input heapDataT data, output heapDataT result,
                            output logic [31:0] status);
    heapCommandT cmd;
    heapDataT    expData;
    heapErrorT   expErr;
    logic [31:0] readData;
    logic        readErr;
    cmd = '{op: op, array: heapArrayT'(arr), index: heapIndexT'(idx), data: data};
    predict(op, arr, idx, data, expData, expErr);
    apbTransfer(1'b1, `HEAP_ADDR_CMD, 32'(cmd), readData, readErr);
    checkValue("prdata", readData, 32'(expData));
    checkValue("pslverr", 32'(readErr), 32'(expErr != errNone));
    result = readData[`HEAP_DATA_BITS-1:0];
    apbTransfer(1'b0, `HEAP_ADDR_RESULT, '0, readData, readErr);
    checkValue("result", readData, 32'(expData));
    apbTransfer(1'b0, `HEAP_ADDR_STATUS, '0, readData, readErr);
    checkValue("status", readData, 32'(expErr));
    status = readData;
  endtask

  task automatic reportTest(input string name);
    testCount++;
    $display("Test %0d %-16s %s", testCount, name,
             (totalErrors() == errorsBefore) ? "ok" : "has errors");
    errorsBefore = totalErrors();
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial begin
    clock  = 1'b0;
    reset  = 1'b0;
    apbReq = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    errorsBefore = 0;

    runCommand(opReset, 0, 0, '0, gotData, gotStatus);
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      runCommand(opAlloc, 0, 0, '0, gotData, gotStatus);
      checkValue("alloc result", 32'(gotData), a);
    end
    runCommand(opAlloc, 0, 0, '0, gotData, gotStatus);
    checkValue("alloc status", gotStatus, 32'(errNoFreeArray));
    runCommand(opFree, 1, 0, '0, gotData, gotStatus);
    runCommand(opFree, 2, 0, '0, gotData, gotStatus);
    runCommand(opAlloc, 0, 0, '0, gotData, gotStatus);
    checkValue("alloc result", 32'(gotData), 2);         // Last freed comes back first
    runCommand(opAlloc, 0, 0, '0, gotData, gotStatus);
    checkValue("alloc result", 32'(gotData), 1);
    reportTest("allocation");

    runCommand(opWrite, 0, 0, 12'h5a5, gotData, gotStatus);
    runCommand(opRead, 0, 0, '0, gotData, gotStatus);
    checkValue("read result", 32'(gotData), 32'h5a5);
    runCommand(opRead, 0, 1, '0, gotData, gotStatus);
    checkValue("read status", gotStatus, 32'(errOutOfBounds));
    runCommand(opWrite, 0, 2, heapDataT'($random(seed)), gotData, gotStatus);
    runCommand(opSize, 0, 0, '0, gotData, gotStatus);
    checkValue("size result", 32'(gotData), 3);
    runCommand(opRead, 0, 2, '0, gotData, gotStatus);
    runCommand(opRead, 0, 3, '0, gotData, gotStatus);
    checkValue("read status", gotStatus, 32'(errOutOfBounds));
    reportTest("write and read");

    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      pushed[i] = heapDataT'($random(seed));
      runCommand(opPush, 3, 0, pushed[i], gotData, gotStatus);
    end
    runCommand(opPush, 3, 0, heapDataT'($random(seed)), gotData, gotStatus);
    checkValue("push status", gotStatus, 32'(errFull));
    for (int i = `HEAP_LENGTH - 1; i >= 0; i--) begin
      runCommand(opPop, 3, 0, '0, gotData, gotStatus);
      checkValue("pop result", 32'(gotData), 32'(pushed[i]));
    end
    runCommand(opPop, 3, 0, '0, gotData, gotStatus);
    checkValue("pop status", gotStatus, 32'(errEmpty));
    reportTest("push and pop");

    runCommand(opWrite, 1, 0, 12'd10, gotData, gotStatus);
    runCommand(opWrite, 1, 1, 12'd20, gotData, gotStatus);
    runCommand(opWrite, 1, 2, 12'd30, gotData, gotStatus);
    for (int i = 0; i < 4; i++) begin
      runCommand(opIndex, 1, 0, heapDataT'(probeIndex[i]), gotData, gotStatus);
      checkValue("index result", 32'(gotData), 3 - i);
      runCommand(opLess, 1, 0, heapDataT'(probeCount[i]), gotData, gotStatus);
      checkValue("less result", 32'(gotData), 3 - i);
      runCommand(opGreater, 1, 0, heapDataT'(probeCount[i]), gotData, gotStatus);
      checkValue("greater result", 32'(gotData), i);
    end
    reportTest("searches");

    runCommand(opFree, 2, 0, '0, gotData, gotStatus);
    runCommand(opRead, 2, 0, '0, gotData, gotStatus);
    checkValue("read status", gotStatus, 32'(errNotAllocated));
    runCommand(opPush, 2, 0, 12'h123, gotData, gotStatus);
    checkValue("push status", gotStatus, 32'(errNotAllocated));
    runCommand(opFree, 2, 0, '0, gotData, gotStatus);
    checkValue("free status", gotStatus, 32'(errNotAllocated));
    runCommand(opReset, 0, 0, '0, gotData, gotStatus);
    runCommand(opSize, 0, 0, '0, gotData, gotStatus);    // Never allocated since reset
    checkValue("size status", gotStatus, 32'(errNotAllocated));
    apbTransfer(1'b1, `HEAP_ADDR_RESULT, 32'h0, rdata, slverr);
    checkValue("pslverr", 32'(slverr), 1);
    apbTransfer(1'b0, `HEAP_ADDR_STATUS, '0, rdata, slverr);
    checkValue("status", rdata, 32'(errBadAddress));
    reportTest("errors");

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, totalErrors());
    if (totalErrors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/heapTb_chk.sv ====
/*
  APB timing checks bound into heapTop. Assumes a master that holds its
  request until pready and never aborts a transfer.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapTb_chk (
  input logic                clock,
  input logic                reset,
  input heapApbPkg::apbReqT  apbReq,
  input heapApbPkg::apbRespT apbResp,
  input heapOpPkg::heapRespT decodeResp,
  input heapOpPkg::heapRespT bankResp [`HEAP_ARRAYS]
);
  logic writeSetup, readSetup;
  logic anyBankValid;
  logic commandSeen;                                     // First command write since reset
  int   failCount = 0;                                   // Failed assertion count

  assign writeSetup = apbReq.psel && !apbReq.penable && apbReq.pwrite;
  assign readSetup  = apbReq.psel && !apbReq.penable && !apbReq.pwrite;

  always_comb begin
    anyBankValid = 1'b0;
    for (int b = 0; b < `HEAP_ARRAYS; b++) begin
      anyBankValid = anyBankValid | bankResp[b].valid;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) commandSeen <= 1'b0;
    else if (writeSetup) commandSeen <= 1'b1;
  end

  // --------------------------------------------------------------------------
  // Latency and handshake rules
  // --------------------------------------------------------------------------
  commandLatency: assert property (@(posedge clock) disable iff (!reset)
    writeSetup |=> !apbResp.pready ##1 !apbResp.pready ##1 apbResp.pready)
    else begin
      failCount = failCount + 1;
      $error("Command write did not finish on its third access cycle");
    end

  readLatency: assert property (@(posedge clock) disable iff (!reset)
    readSetup |=> apbResp.pready)
    else begin
      failCount = failCount + 1;
      $error("Register read did not finish on its first access cycle");
    end

  errorNeedsReady: assert property (@(posedge clock) disable iff (!reset)
    apbResp.pslverr |-> apbResp.pready)
    else begin
      failCount = failCount + 1;
      $error("pslverr high without pready");
    end

  readyInAccess: assert property (@(posedge clock) disable iff (!reset)
    apbResp.pready |-> apbReq.psel && apbReq.penable)
    else begin
      failCount = failCount + 1;
      $error("pready high outside an access phase");
    end

  quietAfterReset: assert property (@(posedge clock) disable iff (!reset)
    !commandSeen |-> !decodeResp.valid && !anyBankValid)
    else begin
      failCount = failCount + 1;
      $error("Response valid before any command");
    end

endmodule

bind heapTop heapTb_chk chk (
  .clock      (clock),
  .reset      (reset),
  .apbReq     (apbReq),
  .apbResp    (apbResp),
  .decodeResp (decodeResp),
  .bankResp   (bankResp)
);

// ==== design/heapTop.sv ====
/*
  Array heap behind an APB slave port.
  Commands take three access cycles, register reads one.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapTop (
  input  logic                clock,
  input  logic                reset,
  input  heapApbPkg::apbReqT  apbReq,
  output heapApbPkg::apbRespT apbResp
);
  import heapOpPkg::*;

  heapBankReqT bankReq  [`HEAP_ARRAYS];                  // One hot valid
  heapRespT    bankResp [`HEAP_ARRAYS];
  heapRespT    decodeResp;                               // Allocator answers

  // --------------------------------------------------------------------------
  // Command decode and allocation
  // --------------------------------------------------------------------------
  heapCommandDecoder decoder (
    .clock      (clock),
    .reset      (reset),
    .apbReq     (apbReq),
    .bankReq    (bankReq),
    .decodeResp (decodeResp)
  );

  // One bank per array
  for (genvar b = 0; b < `HEAP_ARRAYS; b++) begin : gBank
    heapArrayBank bank (
      .clock    (clock),
      .reset    (reset),
      .bankReq  (bankReq[b]),
      .bankResp (bankResp[b])
    );
  end

  heapResponseCollector collector (
    .clock      (clock),
    .reset      (reset),
    .apbReq     (apbReq),
    .bankResp   (bankResp),
    .decodeResp (decodeResp),
    .apbResp    (apbResp)
  );

endmodule

// ==== design/heapResponseCollector.sv ====
/*
  Merges bank and decoder responses and completes APB transfers.
  At most one response is valid per cycle. Reads never wait.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapResponseCollector (
  input  logic                 clock,
  input  logic                 reset,
  input  heapApbPkg::apbReqT   apbReq,
  input  heapOpPkg::heapRespT  bankResp [`HEAP_ARRAYS],
  input  heapOpPkg::heapRespT  decodeResp,
  output heapApbPkg::apbRespT  apbResp
);
  import heapOpPkg::*;

  heapRespT  merged;                                     // Whichever source answered
  heapDataT  resultReg;                                  // Last command result
  heapErrorT statusReg;                                  // Last command error
  logic      readSetup;

  assign readSetup = apbReq.psel && !apbReq.penable && !apbReq.pwrite;

  always_comb begin
    merged = decodeResp;
    for (int b = 0; b < `HEAP_ARRAYS; b++) begin
      if (bankResp[b].valid) merged = bankResp[b];
    end
  end

  // --------------------------------------------------------------------------
  // Result, status and APB completion
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      resultReg <= '0;
      statusReg <= errNone;
      apbResp   <= '0;
    end else begin
      apbResp.pready  <= 1'b0;                           // One cycle pulse
      apbResp.pslverr <= 1'b0;
      if (merged.valid) begin                            // Command done
        resultReg       <= merged.data;
        statusReg       <= merged.error;
        apbResp.prdata  <= 32'(merged.data);
        apbResp.pready  <= 1'b1;
        apbResp.pslverr <= merged.error != errNone;
      end else if (readSetup) begin                      // First access cycle ready
        apbResp.pready <= 1'b1;
        case (apbReq.paddr)
          `HEAP_ADDR_RESULT: apbResp.prdata <= 32'(resultReg);
          `HEAP_ADDR_STATUS: apbResp.prdata <= 32'(statusReg);
          default: begin
            apbResp.prdata  <= '0;
            apbResp.pslverr <= 1'b1;                     // Unmapped or write only
          end
        endcase
      end
    end
  end

endmodule

// ==== design/heapArrayBank.sv ====
/*
  One array of the heap with its size. Allocation is checked upstream.
  Alloc clears the size silently; every other request gets one response.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapArrayBank (
  input  logic                   clock,
  input  logic                   reset,
  input  heapOpPkg::heapBankReqT bankReq,
  output heapOpPkg::heapRespT    bankResp
);
  import heapOpPkg::*;

  heapDataT  elements [`HEAP_LENGTH];                    // Element storage
  heapCountT size;                                       // Elements in use
  heapCountT sizeNext;
  heapIndexT topIdx;                                     // Last used slot
  heapIndexT writeIdx;
  heapDataT  writeData;
  logic      writeEn;
  heapCountT matchPos, countLess, countGreater;
  heapRespT  respNext;

  assign topIdx = size[`HEAP_INDEX_BITS-1:0] - 1'b1;

  // --------------------------------------------------------------------------
  // Searches over the used part of the array
  // --------------------------------------------------------------------------
  always_comb begin
    matchPos     = '0;
    countLess    = '0;
    countGreater = '0;
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      if (i < size) begin
        if (elements[i] == bankReq.data) matchPos = heapCountT'(i + 1); // Last match wins
        if (elements[i] < bankReq.data) countLess = countLess + 1'b1;
        if (elements[i] > bankReq.data) countGreater = countGreater + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Operation decode
  // --------------------------------------------------------------------------
  always_comb begin
    respNext       = '0;
    respNext.valid = bankReq.valid && bankReq.op != opAlloc;
    sizeNext       = size;
    writeEn        = 1'b0;
    writeIdx       = bankReq.index;
    writeData      = bankReq.data;
    if (bankReq.valid) begin
      case (bankReq.op)
        opAlloc: sizeNext = '0;                          // Fresh array is empty
        opWrite: begin
          writeEn       = 1'b1;
          respNext.data = bankReq.data;
          if (heapCountT'(bankReq.index) >= size) sizeNext = heapCountT'(bankReq.index) + 1'b1;
        end
        opRead: begin
          if (heapCountT'(bankReq.index) < size) respNext.data = elements[bankReq.index];
          else respNext.error = errOutOfBounds;
        end
        opSize: respNext.data = heapDataT'(size);
        opPush: begin
          if (size < `HEAP_LENGTH) begin
            writeEn       = 1'b1;
            writeIdx      = size[`HEAP_INDEX_BITS-1:0];
            sizeNext      = size + 1'b1;
            respNext.data = bankReq.data;
          end else begin
            respNext.error = errFull;
          end
        end
        opPop: begin
          if (size != '0) begin
            sizeNext      = size - 1'b1;
            respNext.data = elements[topIdx];
          end else begin
            respNext.error = errEmpty;
          end
        end
        opIndex:   respNext.data = heapDataT'(matchPos);
        opLess:    respNext.data = heapDataT'(countLess);
        opGreater: respNext.data = heapDataT'(countGreater);
        default:   respNext.error = errBadAddress;       // Not routed by decoder
      endcase
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      size     <= '0;
      bankResp <= '0;
    end else begin
      size     <= sizeNext;
      bankResp <= respNext;                              // Arrives with decoder response
    end
  end

  always_ff @(posedge clock) begin
    if (writeEn) elements[writeIdx] <= writeData;
  end

endmodule

// ==== design/heapCommandDecoder.sv ====
/*
  Captures a command in the APB setup phase and keeps the allocation state.
  Freed arrays are reused last in, first out. One command in flight only.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapCommandDecoder (
  input  logic                   clock,
  input  logic                   reset,
  input  heapApbPkg::apbReqT     apbReq,
  output heapOpPkg::heapBankReqT bankReq [`HEAP_ARRAYS],
  output heapOpPkg::heapRespT    decodeResp
);
  import heapOpPkg::*;

  heapCommandT cmd;                                      // Command view of pwdata
  logic        cmdSetup;                                 // Setup phase of a write

  logic [`HEAP_ARRAYS-1:0]    allocated;                 // Allocation table
  logic [`HEAP_ARRAY_BITS:0]  highWater;                 // Arrays ever handed out
  logic [`HEAP_ARRAY_BITS:0]  freeTop;                   // Free stack depth
  heapArrayT                  freeStack [`HEAP_ARRAYS];
  heapArrayT                  stackTopIdx;

  heapBankReqT reqNext [`HEAP_ARRAYS];
  heapRespT    stageNext;
  heapRespT    stageResp;                                // Delay to line up with banks
  heapArrayT   allocPick;
  logic        doReset, doFree, popFree, bumpHigh, grant;

  assign cmdSetup    = apbReq.psel && !apbReq.penable && apbReq.pwrite;
  assign cmd         = heapCommandT'(apbReq.pwdata[$bits(heapCommandT)-1:0]);
  assign stackTopIdx = freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;

  // --------------------------------------------------------------------------
  // Command decode and allocation decisions
  // --------------------------------------------------------------------------
  always_comb begin
    reqNext   = '{default: '0};
    stageNext = '0;
    allocPick = '0;
    doReset   = 1'b0;
    doFree    = 1'b0;
    popFree   = 1'b0;
    bumpHigh  = 1'b0;
    grant     = 1'b0;
    if (cmdSetup) begin
      stageNext.valid = 1'b1;                            // Dropped below for bank work
      if (apbReq.paddr != `HEAP_ADDR_CMD) begin
        stageNext.error = errBadAddress;
      end else begin
        case (cmd.op)
          opReset: doReset = 1'b1;
          opAlloc: begin
            if (freeTop != '0) begin                     // Reuse newest freed array
              allocPick = freeStack[stackTopIdx];
              popFree   = 1'b1;
              grant     = 1'b1;
            end else if (highWater < `HEAP_ARRAYS) begin
              allocPick = highWater[`HEAP_ARRAY_BITS-1:0];
              bumpHigh  = 1'b1;
              grant     = 1'b1;
            end else begin
              stageNext.error = errNoFreeArray;
            end
            if (grant) begin
              stageNext.data     = heapDataT'(allocPick);
              reqNext[allocPick] = '{valid: 1'b1, op: opAlloc, index: '0, data: '0};
            end
          end
          opFree: begin
            if (allocated[cmd.array]) doFree = 1'b1;
            else stageNext.error = errNotAllocated;
          end
          opWrite, opRead, opSize, opPush, opPop, opIndex, opLess, opGreater: begin
            if (allocated[cmd.array]) begin
              stageNext.valid    = 1'b0;                 // Bank answers instead
              reqNext[cmd.array] = '{valid: 1'b1, op: cmd.op, index: cmd.index,
                                     data: cmd.data};
            end else begin
              stageNext.error = errNotAllocated;
            end
          end
          default: stageNext.error = errBadAddress;      // Unknown operation code
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Allocation state and request registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated  <= '0;
      highWater  <= '0;
      freeTop    <= '0;
      bankReq    <= '{default: '0};
      stageResp  <= '0;
      decodeResp <= '0;
    end else begin
      bankReq    <= reqNext;
      stageResp  <= stageNext;
      decodeResp <= stageResp;
      if (doReset) begin
        allocated <= '0;
        highWater <= '0;
        freeTop   <= '0;
      end else begin
        if (grant) allocated[allocPick] <= 1'b1;
        if (bumpHigh) highWater <= highWater + 1'b1;
        if (popFree) freeTop <= freeTop - 1'b1;
        if (doFree) begin
          allocated[cmd.array] <= 1'b0;
          freeTop              <= freeTop + 1'b1;
        end
      end
    end
  end

  // Free stack never overflows since a freed array is no longer allocated
  always_ff @(posedge clock) begin
    if (doFree) freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= cmd.array;
  end

endmodule

// ==== design/heapOpPkg.sv ====
/*
  Operation, command, bank and response types of the array heap.
  Operation codes follow the original memory model numbering.
*/
`include "heap_defs.svh"

package heapOpPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] heapArrayT;       // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] heapIndexT;       // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   heapCountT;       // Size or count, 0 to length
  typedef logic [`HEAP_DATA_BITS-1:0]  heapDataT;        // Element value

  typedef enum logic [4:0] {
    opReset   = 5'd1,                                    // Forget all allocations
    opWrite   = 5'd2,                                    // Write element, grows size
    opRead    = 5'd3,                                    // Read element within size
    opSize    = 5'd4,                                    // Current size
    opIndex   = 5'd7,                                    // Last match position plus one
    opLess    = 5'd8,                                    // Count below input
    opGreater = 5'd9,                                    // Count above input
    opPush    = 5'd14,
    opPop     = 5'd15,
    opAlloc   = 5'd18,                                   // Also clears the bank size
    opFree    = 5'd19
  } heapOpT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,
    errOutOfBounds  = 3'd2,
    errFull         = 3'd3,
    errEmpty        = 3'd4,
    errNoFreeArray  = 3'd5,
    errBadAddress   = 3'd6                               // Also unknown operation
  } heapErrorT;

  // Low bits of pwdata on a command write
  typedef struct packed {
    heapOpT    op;                                       // Bits 20:16
    heapArrayT array;                                    // Bits 15:14
    heapIndexT index;                                    // Bits 13:12
    heapDataT  data;                                     // Bits 11:0
  } heapCommandT;

  typedef struct packed {
    logic      valid;
    heapOpT    op;
    heapIndexT index;
    heapDataT  data;
  } heapBankReqT;

  typedef struct packed {
    logic      valid;                                    // One cycle pulse
    heapDataT  data;
    heapErrorT error;
  } heapRespT;

endpackage

// ==== design/heapApbPkg.sv ====
/*
  APB request and completion bundles of the heap slave port.
  Only a 4-bit byte address is decoded.
*/
package heapApbPkg;

  // Master to slave
  typedef struct packed {
    logic        psel;
    logic        penable;                                // High in access phase
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apbReqT;

  // Slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;                                 // Ends the access phase
    logic        pslverr;                                // Valid only with pready
  } apbRespT;

endpackage

// ==== include/heap_defs.svh ====
/*
  Sizes and APB register map of the array heap.
  Array and index widths must stay matched to the array count and length.
*/
`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// ----------------------------------------------------------------------------
// Heap geometry
// ----------------------------------------------------------------------------
`define HEAP_ARRAY_BITS 2                                // Bits in an array number
`define HEAP_INDEX_BITS 2                                // Bits in an element index
`define HEAP_ARRAYS     4                                // Arrays in the heap
`define HEAP_LENGTH     4                                // Elements per array
`define HEAP_DATA_BITS  12                               // Element width

// ----------------------------------------------------------------------------
// APB address map, byte addresses
// ----------------------------------------------------------------------------
`define HEAP_ADDR_CMD    4'h0                            // Command, write only
`define HEAP_ADDR_RESULT 4'h4                            // Last result, read only
`define HEAP_ADDR_STATUS 4'h8                            // Last error, read only

`endif
